// ==== filelist.f ====
+incdir+include
hw/jpeg_block_pkg.sv
hw/quant_pkg.sv
hw/coef_capture.sv
hw/recip_multiply.sv
hw/round_output.sv
hw/cb_quant_top.sv
test/tb_cb_quant_top.sv

// ==== hw/cb_quant_top.sv ====
// Top level of the pipelined Cb block quantizer, four cycles from enable to out_enable
`timescale 1ns/1ps

module cb_quant_top #(
    parameter quant_pkg::quant_table_t QUANT_TABLE = quant_pkg::CB_DEFAULT_TABLE
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    input  jpeg_block_pkg::coef_block_t coef_in,
    output jpeg_block_pkg::coef_block_t q_out,
    output logic                        out_enable
);

    quant_pkg::prod_block_t ext_block;
    logic                   ext_valid;
    quant_pkg::prod_block_t prod_block;
    logic                   prod_valid;

    coef_capture i_coef_capture (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .coef_in   (coef_in),
        .ext_block (ext_block),
        .ext_valid (ext_valid)
    );

    // Two cycles here, the multiply register and the retiming register
    recip_multiply #(
        .QUANT_TABLE (QUANT_TABLE)
    ) i_recip_multiply (
        .clk        (clk),
        .rst        (rst),
        .ext_valid  (ext_valid),
        .ext_block  (ext_block),
        .prod_block (prod_block),
        .prod_valid (prod_valid)
    );

    round_output i_round_output (
        .clk        (clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod_block (prod_block),
        .q_out      (q_out),
        .out_enable (out_enable)
    );

endmodule

// ==== hw/coef_capture.sv ====
// Input stage of the Cb quantizer: registers a strobed block and widens it to product width
`timescale 1ns/1ps

module coef_capture (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    input  jpeg_block_pkg::coef_block_t coef_in,
    output quant_pkg::prod_block_t      ext_block,
    output logic                        ext_valid
);

    localparam int EXT_BITS = quant_pkg::PROD_WIDTH - jpeg_block_pkg::COEF_WIDTH;
    localparam int SIGN_BIT = jpeg_block_pkg::COEF_WIDTH - 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_valid <= 1'b0;
        end else begin
            ext_valid <= enable;
        end
    end

    // Sign extension only needs to reach the product width, higher bits never matter
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_block <= '0;
        end else if (enable) begin
            for (int lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin
                ext_block[lane] <= {{EXT_BITS{coef_in[lane][SIGN_BIT]}}, coef_in[lane]};
            end
        end
    end

endmodule

// ==== hw/jpeg_block_pkg.sv ====
// Block geometry and coefficient types shared by every stage of the Cb quantizer
package jpeg_block_pkg;

    // One 8x8 block of DCT coefficients
    localparam int BLOCK_DIM = 8;
    localparam int BLOCK_SIZE = BLOCK_DIM * BLOCK_DIM;

    // DCT coefficients and quantized values share the same width
    localparam int COEF_WIDTH = 11;

    typedef logic signed [COEF_WIDTH-1:0] coef_t;

    // Element row * BLOCK_DIM + col holds the coefficient at (row, col)
    typedef coef_t [BLOCK_SIZE-1:0] coef_block_t;

endpackage

// ==== hw/quant_pkg.sv ====
// Arithmetic widths, lane types and the default divisor table of the reciprocal quantizer
package quant_pkg;

    // A reciprocal is 4096 / d, so every product carries 12 fraction bits
    localparam int RECIP_SHIFT = 12;

    // Wide enough to hold 4096 itself when the divisor is 1
    localparam int RECIP_WIDTH = RECIP_SHIFT + 1;

    // Integer part of the product lands exactly on COEF_WIDTH bits
    localparam int PROD_WIDTH = jpeg_block_pkg::COEF_WIDTH + RECIP_SHIFT;

    localparam int DIVISOR_WIDTH = 8;

    typedef logic [RECIP_WIDTH-1:0] recip_t;
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef prod_t [jpeg_block_pkg::BLOCK_SIZE-1:0] prod_block_t;

    typedef logic [DIVISOR_WIDTH-1:0] divisor_t;

    // Same element order as coef_block_t
    typedef divisor_t [jpeg_block_pkg::BLOCK_SIZE-1:0] quant_table_t;

    // Standard JPEG chrominance table in reading order, top-left first
    localparam int CB_TABLE_VALUES [jpeg_block_pkg::BLOCK_SIZE] = '{
        17, 18, 24, 47, 99, 99, 99, 99,
        18, 21, 26, 66, 99, 99, 99, 99,
        24, 26, 56, 99, 99, 99, 99, 99,
        47, 66, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99
    };

    // Packs the reading-order list so that element 0 is the top-left divisor
    function automatic quant_table_t build_cb_table();
        quant_table_t packed_table;
        for (int i = 0; i < jpeg_block_pkg::BLOCK_SIZE; i++) begin
            packed_table[i] = divisor_t'(CB_TABLE_VALUES[i]);
        end
        return packed_table;
    endfunction

    localparam quant_table_t CB_DEFAULT_TABLE = build_cb_table();

endpackage

// ==== hw/recip_multiply.sv ====
// Multiplies every lane of a block by its reciprocal divisor, then retimes the products
`timescale 1ns/1ps

module recip_multiply #(
    parameter quant_pkg::quant_table_t QUANT_TABLE = quant_pkg::CB_DEFAULT_TABLE
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ext_valid,
    input  quant_pkg::prod_block_t ext_block,
    output quant_pkg::prod_block_t prod_block,
    output logic                   prod_valid
);

    // Constant reciprocal per lane, fixed once the table is known
    quant_pkg::recip_t recip [jpeg_block_pkg::BLOCK_SIZE];

    // First pipeline register, holding the raw products
    quant_pkg::prod_block_t mult_block;
    logic                   mult_valid;

    for (genvar lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin : g_recip
        localparam int RECIP_INT = (1 << quant_pkg::RECIP_SHIFT) / int'(QUANT_TABLE[lane]);
        localparam quant_pkg::recip_t RECIP = quant_pkg::recip_t'(RECIP_INT);

        assign recip[lane] = RECIP;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mult_valid <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            mult_valid <= ext_valid;
            prod_valid <= mult_valid;
        end
    end

    // The reciprocal is zero-extended, so the low PROD_WIDTH bits of the product
    // are the two's complement result for negative coefficients too
    always_ff @(posedge clk) begin
        if (rst) begin
            mult_block <= '0;
        end else if (ext_valid) begin
            for (int lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin
                mult_block[lane] <= ext_block[lane] * quant_pkg::prod_t'(recip[lane]);
            end
        end
    end

    // Retiming register after the multipliers
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_block <= '0;
        end else if (mult_valid) begin
            prod_block <= mult_block;
        end
    end

endmodule

// ==== hw/round_output.sv ====
// Output stage of the Cb quantizer: rounds each product half-up and narrows it to a coefficient
`timescale 1ns/1ps

module round_output (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        prod_valid,
    input  quant_pkg::prod_block_t      prod_block,
    output jpeg_block_pkg::coef_block_t q_out,
    output logic                        out_enable
);

    localparam int INT_LSB = quant_pkg::RECIP_SHIFT;
    localparam int INT_MSB = quant_pkg::PROD_WIDTH - 1;

    // Most significant fraction bit, worth one half
    localparam int HALF_BIT = quant_pkg::RECIP_SHIFT - 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_enable <= 1'b0;
        end else begin
            out_enable <= prod_valid;
        end
    end

    // Adding the half bit to the integer part is floor((p + 2048) / 4096),
    // which rounds half up for both signs
    always_ff @(posedge clk) begin
        if (rst) begin
            q_out <= '0;
        end else if (prod_valid) begin
            for (int lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin
                q_out[lane] <= jpeg_block_pkg::coef_t'(
                    prod_block[lane][INT_MSB:INT_LSB] + prod_block[lane][HALF_BIT]);
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the Cb quantizer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_cb_quant_top \
    -Wno-fatal \
    -f filelist.f \
    -o sim_cb_quant

output="$(./obj_dir/sim_cb_quant)"
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

// ==== include/tb_cb_quant_cases.svh ====
// Stimulus rows for the Cb quantizer testbench, included inside the testbench module
`ifndef TB_CB_QUANT_CASES_SVH
`define TB_CB_QUANT_CASES_SVH

// How a row fills the 64 lanes of its block
//   PAT_CONST     every lane is base
//   PAT_RAMP      lane i is base + step * i, wrapped to 11 bits
//   PAT_RANDOM    every lane is drawn from the full coefficient range
//   PAT_EXTREMES  lanes cycle through -1024, -1 and 1023
typedef enum int {
    PAT_CONST,
    PAT_RAMP,
    PAT_RANDOM,
    PAT_EXTREMES
} pattern_kind_e;

typedef struct packed {
    pattern_kind_e kind;
    int            base;
    int            step;
    int            idle;
} stim_row_t;

localparam int NUM_ROWS = 16;

// Idle is the number of cycles without a strobe after the row's block
localparam stim_row_t STIM_ROWS [NUM_ROWS] = '{
    '{PAT_CONST,       0,   0, 3},
    '{PAT_CONST,       9,   0, 2},
    '{PAT_CONST,     100,   0, 1},
    '{PAT_RAMP,        0,   1, 0},
    '{PAT_RAMP,      -32,   1, 0},
    '{PAT_RAMP,     1023, -32, 2},
    '{PAT_CONST,      -1,   0, 1},
    '{PAT_EXTREMES,    0,   0, 0},
    '{PAT_CONST,   -1024,   0, 0},
    '{PAT_CONST,    1023,   0, 4},
    '{PAT_RAMP,    -1024,  31, 0},
    '{PAT_RANDOM,      0,   0, 0},
    '{PAT_RANDOM,      0,   0, 0},
    '{PAT_RANDOM,      0,   0, 5},
    '{PAT_RAMP,      500, -17, 1},
    '{PAT_RANDOM,      0,   0, 3}
};

`endif

// ==== test/tb_cb_quant_top.sv ====
// Testbench for the Cb block quantizer; applies the stimulus table and checks every output block
`timescale 1ns/1ps

module tb_cb_quant_top;

    `include "tb_cb_quant_cases.svh"

    localparam int RESET_CYCLES = 8;
    localparam int PRE_IDLE = 2;
    localparam int TAIL_IDLE = 3;
    localparam int LATENCY = 4;
    localparam int MARGIN = 20;

    // Standard JPEG chrominance divisors, row-major from the top-left
    localparam int CHROMA_DIVISORS [jpeg_block_pkg::BLOCK_SIZE] = '{
        17, 18, 24, 47, 99, 99, 99, 99,
        18, 21, 26, 66, 99, 99, 99, 99,
        24, 26, 56, 99, 99, 99, 99, 99,
        47, 66, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99
    };

    logic                        clk;
    logic                        rst;
    logic                        enable;
    jpeg_block_pkg::coef_block_t coef_in;
    jpeg_block_pkg::coef_block_t q_out;
    logic                        out_enable;

    // Expected blocks and the cycle on which each one is due, in strobe order
    jpeg_block_pkg::coef_block_t exp_q [$];
    int                          due_q [$];
    jpeg_block_pkg::coef_block_t held = '0;

    int cycle_count = 0;
    int errors = 0;
    int strobes = 0;
    int pulses = 0;

    cb_quant_top i_cb_quant_top (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .coef_in    (coef_in),
        .q_out      (q_out),
        .out_enable (out_enable)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic signed [31:0] actual,
                               input logic signed [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    // Round half up of z * (4096 / d) / 4096, wrapped to a signed 11-bit value
    function automatic int expected_lane(input int z, input int d);
        int          recip;
        int          scaled;
        logic [10:0] wrapped;
        recip = 4096 / d;
        scaled = (z * recip + 2048) >>> 12;
        wrapped = scaled[10:0];
        return int'($signed(wrapped));
    endfunction

    function automatic jpeg_block_pkg::coef_block_t quantize_block(
        input jpeg_block_pkg::coef_block_t blk
    );
        jpeg_block_pkg::coef_block_t result;
        for (int lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin
            result[lane] = jpeg_block_pkg::coef_t'(expected_lane(int'(blk[lane]),
                CHROMA_DIVISORS[lane]));
        end
        return result;
    endfunction

    function automatic jpeg_block_pkg::coef_block_t make_block(input stim_row_t row);
        jpeg_block_pkg::coef_block_t blk;
        for (int lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin
            case (row.kind)
                PAT_CONST:  blk[lane] = jpeg_block_pkg::coef_t'(row.base);
                PAT_RAMP:   blk[lane] = jpeg_block_pkg::coef_t'(row.base + row.step * lane);
                PAT_RANDOM: blk[lane] = jpeg_block_pkg::coef_t'($urandom());
                default: begin
                    if (lane % 3 == 0) blk[lane] = -11'sd1024;
                    else if (lane % 3 == 1) blk[lane] = -11'sd1;
                    else blk[lane] = 11'sd1023;
                end
            endcase
        end
        return blk;
    endfunction

    function automatic int run_cycle_limit();
        int total;
        total = RESET_CYCLES + PRE_IDLE + TAIL_IDLE + LATENCY + MARGIN;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += 1 + STIM_ROWS[r].idle;
        end
        return total;
    endfunction

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk) begin : output_monitor
        int due;
        if (!rst) begin
            if (out_enable) begin
                pulses++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("At %0t out_enable went high with no block outstanding", $time);
                end else begin
                    held = exp_q.pop_front();
                    due = due_q.pop_front();
                    check_value("out_enable arrival cycle", cycle_count, due);
                end
            end
            // Outside a pulse q_out must still show the last block
            for (int lane = 0; lane < jpeg_block_pkg::BLOCK_SIZE; lane++) begin
                check_value($sformatf("q_out[%0d]", lane), q_out[lane], held[lane]);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = run_cycle_limit();
        while (cycle_count < limit) @(posedge clk);
        $display("Run stopped after %0d cycles without finishing the stimulus table", limit);
        $display("Errors: %0d", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        jpeg_block_pkg::coef_block_t blk;
        void'($urandom(32'h1e24_b2ca));
        rst = 1'b1;
        enable = 1'b0;
        coef_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (PRE_IDLE) @(negedge clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            blk = make_block(STIM_ROWS[r]);
            enable = 1'b1;
            coef_in = blk;
            exp_q.push_back(quantize_block(blk));
            due_q.push_back(cycle_count + LATENCY);
            strobes++;
            @(negedge clk);
            enable = 1'b0;
            repeat (STIM_ROWS[r].idle) @(negedge clk);
        end

        // The last block is due LATENCY cycles after its strobe
        repeat (LATENCY + TAIL_IDLE) @(negedge clk);
        @(posedge clk);

        check_value("out_enable pulse count", pulses, strobes);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected blocks never appeared on q_out", exp_q.size());
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
